// ==== common/mpu_pkg.sv ====
// Shared word type, header opcode and sequencer state enums, and buffer and memory sizes

package mpu_pkg;

	//////////////////////////////////////////////////
	// Word and header fields
	//////////////////////////////////////////////////
	localparam int word_width = 32;

	typedef logic [word_width-1:0] word_t;

	// Numeric value of the first header word
	typedef enum logic [word_width-1:0] {
		op_store = 32'd0,
		op_load  = 32'd1
	} opcode_e;

	//////////////////////////////////////////////////
	// Buffer and memory sizes
	//////////////////////////////////////////////////
	localparam int buff_size  = 16;
	localparam int buff_width = $clog2(buff_size);  // Pointer width

	localparam int mem_depth  = 256;
	localparam int addr_width = 8;                   // Addresses wrap at mem_depth

	// Transfer sequencer
	typedef enum logic [2:0] {
		recv_op,
		recv_stride,
		recv_length,
		recv_base,
		run_store,
		run_load,
		finish
	} serv_state_e;

endpackage

// ==== data_service/data_service.sv ====
// Header decode and strided store or load sequencing between the host stream and data memory
`timescale 1ns/10ps

module data_service import mpu_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  ext_in_valid,
	output logic                  ext_in_ready,
	input  word_t                 ext_in_data,
	output logic                  ext_out_valid,
	input  logic                  ext_out_ready,
	output word_t                 ext_out_data,
	output logic                  busy,
	output logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	output logic                  mem_req_write,
	output logic [addr_width-1:0] mem_req_addr,
	output word_t                 mem_req_data,
	input  logic                  mem_rd_valid,
	input  word_t                 mem_rd_data
);

	serv_state_e           state;
	opcode_e               op;
	word_t                 stride;
	word_t                 length;
	logic [addr_width-1:0] addr;         // Base, then stepped by stride
	word_t                 issue_count;  // Memory requests accepted
	word_t                 xfer_count;   // Host words in or out
	logic [buff_width:0]   inflight;     // Reads awaiting response
	logic [buff_width+1:0] space_used;

	logic  in_header;
	logic  is_store;
	logic  is_load;
	logic  in_fire;
	logic  out_fire;
	logic  req_fire;
	logic  issue_left;
	logic  done;

	logic                buf_wr;
	word_t               buf_wr_data;
	logic                buf_rd;
	word_t               buf_rd_data;
	logic                buf_full;
	logic                buf_empty;
	logic [buff_width:0] buf_count;

	//////////////////////////////////////////////////
	// Handshakes and steering
	//////////////////////////////////////////////////
	assign in_header  = state inside {recv_op, recv_stride, recv_length, recv_base};
	assign is_store   = state == run_store;
	assign is_load    = state == run_load;
	assign busy       = state != recv_op;
	assign in_fire    = ext_in_valid & ext_in_ready;
	assign out_fire   = ext_out_valid & ext_out_ready;
	assign req_fire   = mem_req_valid & mem_req_ready;
	assign issue_left = issue_count != length;
	assign done       = ~issue_left & (xfer_count == length);

	// Room for the buffer contents plus every outstanding read
	assign space_used = {1'b0, buf_count} + {1'b0, inflight};

	assign ext_in_ready  = in_header | (is_store & ~buf_full & (xfer_count != length));
	assign ext_out_valid = is_load & ~buf_empty;
	assign ext_out_data  = buf_rd_data;

	assign mem_req_valid = issue_left & ((is_store & ~buf_empty) |
		(is_load & (space_used < (buff_width+2)'(buff_size))));
	assign mem_req_write = is_store;
	assign mem_req_addr  = addr;
	assign mem_req_data  = buf_rd_data;

	assign buf_wr      = (is_store & in_fire) | (is_load & mem_rd_valid);
	assign buf_wr_data = is_store ? ext_in_data : mem_rd_data;
	assign buf_rd      = (is_store & req_fire) | out_fire;

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= recv_op;
		end else begin
			case (state)
				recv_op:     if (in_fire) state <= recv_stride;
				recv_stride: if (in_fire) state <= recv_length;
				recv_length: if (in_fire) state <= recv_base;
				recv_base: begin
					if (in_fire) begin
						if (length == '0) begin
							state <= finish;  // Nothing to move
						end else begin
							state <= (op == op_store) ? run_store : run_load;
						end
					end
				end
				run_store,
				run_load:    if (done) state <= finish;
				default:     state <= recv_op;
			endcase
		end
	end

	// Header fields
	always_ff @(posedge clock) begin
		if (in_fire) begin
			case (state)
				recv_op:     op     <= (ext_in_data == op_store) ? op_store : op_load;
				recv_stride: stride <= ext_in_data;
				recv_length: length <= ext_in_data;
				default:     ;
			endcase
		end
	end

	// Address wraps in addr_width bits
	always_ff @(posedge clock) begin
		if (in_fire & (state == recv_base)) begin
			addr <= ext_in_data[addr_width-1:0];
		end else if (req_fire) begin
			addr <= addr + stride[addr_width-1:0];
		end
	end

	//////////////////////////////////////////////////
	// Word counters
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_count <= '0;
			xfer_count  <= '0;
		end else if (in_fire & (state == recv_base)) begin
			issue_count <= '0;
			xfer_count  <= '0;
		end else begin
			if (req_fire) begin
				issue_count <= issue_count + 1'b1;
			end
			if ((is_store & in_fire) | out_fire) begin
				xfer_count <= xfer_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			inflight <= '0;
		end else begin
			case ({is_load & req_fire, mem_rd_valid})
				2'b10:   inflight <= inflight + 1'b1;
				2'b01:   inflight <= inflight - 1'b1;
				default: inflight <= inflight;
			endcase
		end
	end

	ring_buffer u_ring_buffer (
		.clock   (clock),
		.reset   (reset),
		.wr_en   (buf_wr),
		.wr_data (buf_wr_data),
		.rd_en   (buf_rd),
		.rd_data (buf_rd_data),
		.full    (buf_full),
		.empty   (buf_empty),
		.count   (buf_count)
	);

endmodule

// ==== data_service/ring_buffer.sv ====
// Word FIFO between host and data memory, head entry shown combinationally
`timescale 1ns/10ps

module ring_buffer import mpu_pkg::*; (
	input  logic                clock,
	input  logic                reset,
	input  logic                wr_en,
	input  word_t               wr_data,
	input  logic                rd_en,
	output word_t               rd_data,
	output logic                full,
	output logic                empty,
	output logic [buff_width:0] count
);

	word_t                 storage [buff_size];
	logic [buff_width-1:0] wr_ptr;
	logic [buff_width-1:0] rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	assign full    = count == (buff_width+1)'(buff_size);
	assign empty   = count == '0;
	assign do_wr   = wr_en & ~full;   // Drop writes into a full buffer
	assign do_rd   = rd_en & ~empty;
	assign rd_data = storage[rd_ptr];

	// Storage, no reset
	always_ff @(posedge clock) begin
		if (do_wr) begin
			storage[wr_ptr] <= wr_data;
		end
	end

	// Pointers wrap at buff_size
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

// ==== dv/mpu_data_assertions.sv ====
// Stream handshake, busy and reset assertions, bound into mpu_data_top
`timescale 1ns/10ps

module mpu_data_assertions import mpu_pkg::*; (
	input logic                  clock,
	input logic                  reset,
	input logic                  ext_in_valid,
	input logic                  ext_in_ready,
	input word_t                 ext_in_data,
	input logic                  ext_out_valid,
	input logic                  ext_out_ready,
	input word_t                 ext_out_data,
	input logic                  busy,
	input logic                  mem_req_valid,
	input logic                  mem_req_ready,
	input logic                  mem_req_write,
	input logic [addr_width-1:0] mem_req_addr,
	input word_t                 mem_req_data
);

	//////////////////////////////////////////////////
	// Stalled words hold steady
	//////////////////////////////////////////////////
	in_hold: assert property (@(posedge clock) disable iff (reset)
		ext_in_valid && !ext_in_ready |=> ext_in_valid && $stable(ext_in_data))
		else $error("Host input word changed while stalled");

	out_hold: assert property (@(posedge clock) disable iff (reset)
		ext_out_valid && !ext_out_ready |=> ext_out_valid && $stable(ext_out_data))
		else $error("Host output word changed while stalled");

	req_hold: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write) &&
		$stable(mem_req_addr) && $stable(mem_req_data))
		else $error("Memory request changed while stalled");

	//////////////////////////////////////////////////
	// Busy and reset
	//////////////////////////////////////////////////
	out_needs_busy: assert property (@(posedge clock) disable iff (reset)
		!busy |-> !ext_out_valid)
		else $error("Output valid while not busy");

	busy_fall: assert property (@(posedge clock) disable iff (reset)
		$fell(busy) |-> ext_in_ready && !ext_out_valid && !mem_req_valid)
		else $error("Busy fell outside the idle header state");

	reset_quiet: assert property (@(posedge clock)
		reset |=> !ext_out_valid && !busy && !mem_req_valid && ext_in_ready)
		else $error("Outputs not in reset state");

endmodule

bind mpu_data_top mpu_data_assertions u_assertions (
	.clock         (clock),
	.reset         (reset),
	.ext_in_valid  (ext_in_valid),
	.ext_in_ready  (ext_in_ready),
	.ext_in_data   (ext_in_data),
	.ext_out_valid (ext_out_valid),
	.ext_out_ready (ext_out_ready),
	.ext_out_data  (ext_out_data),
	.busy          (busy),
	.mem_req_valid (mem_req_valid),
	.mem_req_ready (mem_req_ready),
	.mem_req_write (mem_req_write),
	.mem_req_addr  (mem_req_addr),
	.mem_req_data  (mem_req_data)
);

// ==== dv/mpu_data_tb.sv ====
// Top-level testbench that runs strided stores and loads through mpu_data_top and checks the loads
`timescale 1ns/10ps

module mpu_data_tb import mpu_pkg::*; ();

	localparam int total_words    = 8*2 + 12*2 + 30*2 + 30 + 4*2;
	localparam int timeout_cycles = 60*total_words + 200;

	logic  clock;
	logic  reset;
	logic  ext_in_valid;
	logic  ext_in_ready;
	word_t ext_in_data;
	logic  ext_out_valid;
	logic  ext_out_ready;
	word_t ext_out_data;
	logic  busy;

	logic [15:0] host_lfsr;   // Gaps and store data
	logic [15:0] ready_lfsr;  // Output ready pattern
	int unsigned cycle;
	int unsigned hold_end;    // Output ready held low until this cycle
	int unsigned out_total;
	word_t       model [mem_depth];
	word_t       exp_q [$];
	word_t       exp_word;

	mpu_data_top dut (
		.clock         (clock),
		.reset         (reset),
		.ext_in_valid  (ext_in_valid),
		.ext_in_ready  (ext_in_ready),
		.ext_in_data   (ext_in_data),
		.ext_out_valid (ext_out_valid),
		.ext_out_ready (ext_out_ready),
		.ext_out_data  (ext_out_data),
		.busy          (busy)
	);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic word_t rand_word();
		word_t w;
		for (int i = 0; i < word_width; i++) begin
			host_lfsr = lfsr_step(host_lfsr);
			w[i] = host_lfsr[0];
		end
		return w;
	endfunction

	// Low address bits of base plus index times stride
	function automatic logic [addr_width-1:0] strided_addr(word_t base, word_t stride, int idx);
		word_t full_addr;
		full_addr = base + word_t'(idx) * stride;
		return full_addr[addr_width-1:0];
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Starts right after a rising edge and returns right after the accepting edge
	task automatic send_word(input word_t w);
		logic g0;
		logic g1;
		host_lfsr = lfsr_step(host_lfsr);
		g0 = host_lfsr[0];
		host_lfsr = lfsr_step(host_lfsr);
		g1 = host_lfsr[0];
		if (g0 & g1) begin
			ext_in_valid <= 1'b0;  // Host gap
			@(posedge clock);
		end
		ext_in_valid <= 1'b1;
		ext_in_data  <= w;
		@(posedge clock);
		while (!ext_in_ready) @(posedge clock);
	endtask

	task automatic send_header(input opcode_e op, input word_t stride, input word_t len,
			input word_t base);
		send_word(word_t'(op));
		send_word(stride);
		send_word(len);
		send_word(base);
	endtask

	task automatic wait_idle();
		ext_in_valid <= 1'b0;
		do @(posedge clock); while (busy);
	endtask

	task automatic store_words(input word_t base, input word_t stride, input int len);
		word_t w;
		send_header(op_store, stride, word_t'(len), base);
		for (int i = 0; i < len; i++) begin
			w = rand_word();
			model[strided_addr(base, stride, i)] = w;
			send_word(w);
		end
		wait_idle();
	endtask

	task automatic load_words(input word_t base, input word_t stride, input int len,
			input int hold);
		int unsigned start;
		start = out_total;
		for (int i = 0; i < len; i++) begin
			exp_q.push_back(model[strided_addr(base, stride, i)]);
		end
		if (hold > 0) begin
			hold_end <= cycle + hold;
		end
		send_header(op_load, stride, word_t'(len), base);
		wait_idle();
		assert (out_total - start == len) else
			report_failure($sformatf("ERROR t=%0t output word count expected %0d actual %0d",
				$time, len, out_total - start));
	endtask

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	always @(posedge clock) begin
		if (reset || cycle < hold_end) begin
			ext_out_ready <= 1'b0;
		end else begin
			ready_lfsr = lfsr_step(ready_lfsr);
			ext_out_ready <= ready_lfsr[0];
		end
	end

	// Load checker
	always @(posedge clock) begin
		if (!reset && ext_out_valid && ext_out_ready) begin
			assert (exp_q.size() != 0) else
				report_failure("Output word returned with no load word outstanding");
			exp_word = exp_q.pop_front();
			assert (ext_out_data == exp_word) else
				report_failure($sformatf("ERROR t=%0t ext_out_data expected %h actual %h",
					$time, exp_word, ext_out_data));
			out_total <= out_total + 1;
		end
	end

	initial begin : watchdog
		repeat (timeout_cycles) @(posedge clock);
		report_failure("Timeout, the transfers did not finish in the allowed time");
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		clock         = 1'b0;
		reset         = 1'b1;
		ext_in_valid  = 1'b0;
		ext_in_data   = '0;
		ext_out_ready = 1'b0;
		host_lfsr     = 16'd91;
		ready_lfsr    = 16'd91;
		cycle         = 0;
		hold_end      = 0;
		out_total     = 0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		store_words(32'd32, 32'd1, 8);       // Unit stride round trip
		load_words(32'd32, 32'd1, 8, 0);
		store_words(32'd240, 32'd3, 12);     // Wraps past the memory end
		load_words(32'd240, 32'd3, 12, 0);
		store_words(32'd100, 32'd2, 30);     // Longer than the buffer
		load_words(32'd100, 32'd2, 30, 0);
		load_words(32'd100, 32'd2, 30, 40);  // Output stalled while the buffer fills
		load_words(32'd8, 32'd1, 0, 0);      // Empty transfer
		store_words(32'd200, 32'd5, 4);
		load_words(32'd200, 32'd5, 4, 0);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== mpu_data_top.f ====
common/mpu_pkg.sv
data_service/ring_buffer.sv
data_service/data_service.sv
src/data_memory.sv
src/mpu_data_top.sv
dv/mpu_data_assertions.sv
dv/mpu_data_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status is the simulator's

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f mpu_data_top.f \
	--top-module mpu_data_tb \
	--Mdir obj_dir \
	-o mpu_data_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/mpu_data_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
fi
exit $status

// ==== src/data_memory.sv ====
// Single-port word memory with a valid/ready request port and registered read data
`timescale 1ns/10ps

module data_memory import mpu_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  logic                  req_write,
	input  logic [addr_width-1:0] req_addr,
	input  word_t                 req_data,
	output logic                  rd_valid,
	output word_t                 rd_data
);

	word_t mem [mem_depth];
	logic  recover;   // Write recovery cycle
	logic  accept;

	assign req_ready = ~recover;
	assign accept    = req_valid & req_ready;

	//////////////////////////////////////////////////
	// Array access
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (accept & req_write) begin
			mem[req_addr] <= req_data;
		end
	end

	// Read data one cycle after the request
	always_ff @(posedge clock) begin
		if (accept & ~req_write) begin
			rd_data <= mem[req_addr];
		end
	end

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			recover <= 1'b0;
		end else begin
			recover <= accept & req_write;  // Not ready for one cycle after a write
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= accept & ~req_write;
		end
	end

endmodule

// ==== src/mpu_data_top.sv ====
// Data service top level, host stream in and out with the local data memory behind it
`timescale 1ns/10ps

module mpu_data_top import mpu_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  ext_in_valid,
	output logic  ext_in_ready,
	input  word_t ext_in_data,
	output logic  ext_out_valid,
	input  logic  ext_out_ready,
	output word_t ext_out_data,
	output logic  busy
);

	// Memory request and response
	logic                  mem_req_valid;
	logic                  mem_req_ready;
	logic                  mem_req_write;
	logic [addr_width-1:0] mem_req_addr;
	word_t                 mem_req_data;
	logic                  mem_rd_valid;
	word_t                 mem_rd_data;

	data_service u_data_service (
		.clock         (clock),
		.reset         (reset),
		.ext_in_valid  (ext_in_valid),
		.ext_in_ready  (ext_in_ready),
		.ext_in_data   (ext_in_data),
		.ext_out_valid (ext_out_valid),
		.ext_out_ready (ext_out_ready),
		.ext_out_data  (ext_out_data),
		.busy          (busy),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req_write (mem_req_write),
		.mem_req_addr  (mem_req_addr),
		.mem_req_data  (mem_req_data),
		.mem_rd_valid  (mem_rd_valid),
		.mem_rd_data   (mem_rd_data)
	);

	data_memory u_data_memory (
		.clock     (clock),
		.reset     (reset),
		.req_valid (mem_req_valid),
		.req_ready (mem_req_ready),
		.req_write (mem_req_write),
		.req_addr  (mem_req_addr),
		.req_data  (mem_req_data),
		.rd_valid  (mem_rd_valid),
		.rd_data   (mem_rd_data)
	);

endmodule
